//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
FILELIST  ?= filelist.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    typedef enum logic [2:0] {
        STEP_ALLOC,
        STEP_STORE,
        STEP_COMMIT,
        STEP_LOAD,
        STEP_DRAIN,
        STEP_CAN,
        STEP_QUIET
    } step_kind_t;

    // flag is the commit port for commits and is_unsigned for loads
    typedef struct packed {
        step_kind_t          kind;
        logic [ROB_ID_W-1:0] robid;
        logic [ROB_ID_W-1:0] sqid;
        logic [PREG_W-1:0]   prd;
        logic                flag;
        ls_size_t            size;
        logic [XLEN-1:0]     base;
        logic [XLEN-1:0]     imm;
        logic [XLEN-1:0]     data;
        logic [XLEN-1:0]     expected;
    } step_t;

    logic                clock;
    logic                rst_n;
    logic                mem_instr_valid;
    logic                mem_instr_ready;
    mem_issue_t          mem_issue;
    logic                disp2sq_valid;
    logic [ROB_ID_W-1:0] disp2sq_robid;
    logic                sq_can_alloc;
    logic [ROB_ID_W-1:0] sq2disp_sqid;
    commit_t             commit0;
    commit_t             commit1;
    memwb_t              memwb;
    tbus_req_t           tbus_req;
    tbus_resp_t          tbus_resp;

    step_t               steps [64];
    int                  num_rows;
    logic                table_built;
    int                  alloc_count;
    logic [ROB_ID_W-1:0] sqid_of [64];
    logic [XLEN-1:0]     shadow [64];
    logic [XLEN-1:0]     mem [64];
    int                  writes_done;
    int                  writes_expected;

    // Bus model state
    tbus_req_t           cur;
    tbus_req_t           held;
    logic                held_valid;
    logic                pending;
    int                  delay;

    exu_top #(
        .sq_depth(SQ_DEPTH)
    ) i_exu_top (
        .clock          (clock),
        .rst_n          (rst_n),
        .mem_instr_valid(mem_instr_valid),
        .mem_instr_ready(mem_instr_ready),
        .mem_issue      (mem_issue),
        .disp2sq_valid  (disp2sq_valid),
        .disp2sq_robid  (disp2sq_robid),
        .sq_can_alloc   (sq_can_alloc),
        .sq2disp_sqid   (sq2disp_sqid),
        .commit0        (commit0),
        .commit1        (commit1),
        .memwb          (memwb),
        .tbus_req       (tbus_req),
        .tbus_resp      (tbus_resp)
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [63:0] init_word(input logic [5:0] idx);
        return 64'h8877_6655_4433_2211 ^ {8{2'b00, idx}};
    endfunction

    function automatic logic [63:0] lane_mask(input ls_size_t size, input logic [2:0] off);
        logic [63:0] m;
        case (size)
            LS_BYTE: m = 64'hff;
            LS_HALF: m = 64'hffff;
            LS_WORD: m = 64'hffff_ffff;
            default: m = '1;
        endcase
        return m << {off, 3'b000};
    endfunction

    function automatic logic [63:0] load_value(input logic [63:0] word, input logic [2:0] off,
                                               input ls_size_t size, input logic uns);
        logic [63:0] v;
        v = word >> {off, 3'b000};
        case (size)
            LS_BYTE: return uns ? {56'b0, v[7:0]} : {{56{v[7]}}, v[7:0]};
            LS_HALF: return uns ? {48'b0, v[15:0]} : {{48{v[15]}}, v[15:0]};
            LS_WORD: return uns ? {32'b0, v[31:0]} : {{32{v[31]}}, v[31:0]};
            default: return v;
        endcase
    endfunction

    task automatic push_row(input step_t s);
        steps[num_rows] = s;
        num_rows++;
    endtask

    task automatic alloc_row(input logic [5:0] robid);
        step_t s;
        s = '0;
        s.kind = STEP_ALLOC;
        s.robid = robid;
        s.expected = 64'(alloc_count % SQ_DEPTH);
        sqid_of[robid] = ROB_ID_W'(alloc_count % SQ_DEPTH);
        alloc_count++;
        push_row(s);
    endtask

    task automatic store_row(input logic [5:0] robid, input logic [63:0] base,
                             input logic [63:0] imm, input logic [63:0] data,
                             input ls_size_t size);
        step_t       s;
        logic [63:0] addr;
        logic [63:0] m;
        addr = base + imm;
        m = lane_mask(size, addr[2:0]);
        shadow[addr[8:3]] = (shadow[addr[8:3]] & ~m) | ((data << {addr[2:0], 3'b000}) & m);
        s = '0;
        s.kind = STEP_STORE;
        s.robid = robid;
        s.sqid = sqid_of[robid];
        s.base = base;
        s.imm = imm;
        s.data = data;
        s.size = size;
        push_row(s);
    endtask

    task automatic commit_row(input logic [5:0] robid, input logic port);
        step_t s;
        s = '0;
        s.kind = STEP_COMMIT;
        s.robid = robid;
        s.flag = port;
        push_row(s);
    endtask

    task automatic load_row(input logic [5:0] robid, input logic [5:0] prd,
                            input logic [63:0] base, input logic [63:0] imm,
                            input ls_size_t size, input logic uns);
        step_t       s;
        logic [63:0] addr;
        addr = base + imm;
        s = '0;
        s.kind = STEP_LOAD;
        s.robid = robid;
        s.prd = prd;
        s.base = base;
        s.imm = imm;
        s.size = size;
        s.flag = uns;
        s.expected = load_value(shadow[addr[8:3]], addr[2:0], size, uns);
        push_row(s);
    endtask

    task automatic drain_row(input logic [63:0] addr);
        step_t s;
        s = '0;
        s.kind = STEP_DRAIN;
        s.base = addr;
        s.expected = shadow[addr[8:3]];
        push_row(s);
    endtask

    task automatic simple_row(input step_kind_t kind, input logic [63:0] expected);
        step_t s;
        s = '0;
        s.kind = kind;
        s.expected = expected;
        push_row(s);
    endtask

    task automatic build_table();
        for (int i = 0; i < 64; i++) begin
            shadow[i] = init_word(6'(i));
            mem[i] = init_word(6'(i));
        end
        // Each size at a different offset, both commit ports
        alloc_row(1); store_row(1, 64'h40, 64'h3, 64'ha5, LS_BYTE);
        commit_row(1, 1'b0); drain_row(64'h40);
        alloc_row(2); store_row(2, 64'h80, 64'h6, 64'hbeef, LS_HALF);
        commit_row(2, 1'b1); drain_row(64'h80);
        alloc_row(3); store_row(3, 64'hc0, 64'h4, 64'hdead_beef, LS_WORD);
        commit_row(3, 1'b0); drain_row(64'hc0);
        alloc_row(4); store_row(4, 64'h100, 64'h0, 64'h0123_4567_89ab_cdef, LS_DOUBLE);
        commit_row(4, 1'b1); drain_row(64'h100);
        alloc_row(5); store_row(5, 64'h14f, 64'hffff_ffff_ffff_fffe, 64'h1234_5677, LS_BYTE);
        commit_row(5, 1'b0); drain_row(64'h148);
        alloc_row(6); store_row(6, 64'h1c0, 64'h2, 64'hffff_0042, LS_HALF);
        commit_row(6, 1'b1); drain_row(64'h1c0);
        // Loads, signed and unsigned
        load_row(20, 7, 64'ha0, 64'h7, LS_BYTE, 1'b0);
        load_row(21, 8, 64'ha0, 64'h7, LS_BYTE, 1'b1);
        load_row(22, 9, 64'ha8, 64'h6, LS_HALF, 1'b0);
        load_row(23, 10, 64'ha8, 64'h2, LS_HALF, 1'b1);
        load_row(24, 11, 64'hb0, 64'h4, LS_WORD, 1'b0);
        load_row(25, 12, 64'hb0, 64'h4, LS_WORD, 1'b1);
        load_row(26, 13, 64'hb8, 64'h0, LS_DOUBLE, 1'b0);
        load_row(27, 14, 64'h40, 64'h0, LS_DOUBLE, 1'b0);
        load_row(28, 15, 64'h80, 64'h6, LS_HALF, 1'b0);
        // Fill the queue, then hold stores uncommitted
        alloc_row(10); alloc_row(11); alloc_row(12); alloc_row(13);
        simple_row(STEP_CAN, 64'h0);
        store_row(10, 64'h180, 64'h1, 64'h77, LS_BYTE);
        store_row(11, 64'h188, 64'h0, 64'hcafe, LS_HALF);
        store_row(12, 64'h190, 64'h4, 64'h1357_9bdf, LS_WORD);
        store_row(13, 64'h198, 64'h0, 64'h0f0f_1e1e_2d2d_3c3c, LS_DOUBLE);
        simple_row(STEP_QUIET, 64'h0);
        commit_row(10, 1'b1); drain_row(64'h180);
        simple_row(STEP_CAN, 64'h1);
        commit_row(11, 1'b0); drain_row(64'h188);
        commit_row(12, 1'b1); commit_row(13, 1'b0);
        load_row(30, 16, 64'h20, 64'h3, LS_BYTE, 1'b0);
        drain_row(64'h190); drain_row(64'h198);
    endtask

    task automatic issue_op(input step_t s);
        mem_issue_t op;
        op = '0;
        op.robid = s.robid;
        op.sqid = s.sqid;
        op.src1 = s.base;
        op.src2 = s.data;
        op.imm = s.imm;
        op.prd = s.prd;
        op.is_load = (s.kind == STEP_LOAD);
        op.is_store = (s.kind == STEP_STORE);
        op.is_unsigned = s.flag;
        op.ls_size = s.size;
        @(negedge clock);
        mem_issue = op;
        mem_instr_valid = 1'b1;
        while (!mem_instr_ready) @(negedge clock);
        @(negedge clock);
        mem_instr_valid = 1'b0;
    endtask

    task automatic run_step(input step_t s);
        case (s.kind)
            STEP_ALLOC: begin
                @(negedge clock);
                check("sq_can_alloc", 64'(sq_can_alloc), 64'h1);
                check("sq2disp_sqid", 64'(sq2disp_sqid), s.expected);
                disp2sq_valid = 1'b1;
                disp2sq_robid = s.robid;
                @(negedge clock);
                disp2sq_valid = 1'b0;
            end
            STEP_STORE: begin
                issue_op(s);
                // Store writeback lands one cycle after accept
                check("memwb.valid", 64'(memwb.valid), 64'h1);
                check("memwb.need_to_wb", 64'(memwb.need_to_wb), 64'h0);
                check("memwb.robid", 64'(memwb.robid), 64'(s.robid));
            end
            STEP_COMMIT: begin
                @(negedge clock);
                if (s.flag) begin
                    commit1 = '{valid: 1'b1, robid: s.robid};
                end else begin
                    commit0 = '{valid: 1'b1, robid: s.robid};
                end
                writes_expected++;
                @(negedge clock);
                commit0 = '0;
                commit1 = '0;
            end
            STEP_LOAD: begin
                issue_op(s);
                while (!memwb.valid) @(negedge clock);
                check("memwb.result", memwb.result, s.expected);
                check("memwb.robid", 64'(memwb.robid), 64'(s.robid));
                check("memwb.prd", 64'(memwb.prd), 64'(s.prd));
                check("memwb.need_to_wb", 64'(memwb.need_to_wb), 64'h1);
            end
            STEP_DRAIN: begin
                while (writes_done != writes_expected) @(negedge clock);
                check("mem doubleword", mem[s.base[8:3]], s.expected);
            end
            STEP_CAN: begin
                @(negedge clock);
                check("sq_can_alloc", 64'(sq_can_alloc), s.expected);
            end
            default: begin
                repeat (8) begin
                    @(negedge clock);
                    check("tbus_index_valid", 64'(tbus_req.valid), 64'h0);
                end
            end
        endcase
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Data bus memory with random stalls and latency
    initial begin
        void'($urandom(62));
        tbus_resp = '0;
        held_valid = 1'b0;
        pending = 1'b0;
        forever begin
            @(negedge clock);
            tbus_resp.operation_done = 1'b0;
            if (!rst_n) begin
                tbus_resp.ready = 1'b0;
                held_valid = 1'b0;
                pending = 1'b0;
            end else if (tbus_resp.ready) begin
                tbus_resp.ready = 1'b0;
                held_valid = 1'b0;
                pending = 1'b1;
                delay = 1 + int'($urandom % 4);
            end else if (pending) begin
                delay--;
                if (delay == 0) begin
                    pending = 1'b0;
                    if (cur.op_type == TBUS_WRITE) begin
                        mem[cur.index[8:3]] = (mem[cur.index[8:3]] & ~cur.write_mask) |
                                              (cur.write_data & cur.write_mask);
                        writes_done++;
                    end
                    tbus_resp.read_data = mem[cur.index[8:3]];
                    tbus_resp.operation_done = 1'b1;
                end
            end else if (tbus_req.valid) begin
                if (held_valid) begin
                    check("tbus_index", tbus_req.index, held.index);
                    check("tbus_write_data", tbus_req.write_data, held.write_data);
                    check("tbus_write_mask", tbus_req.write_mask, held.write_mask);
                    check("tbus_op_type", 64'(tbus_req.op_type), 64'(held.op_type));
                end
                held = tbus_req;
                held_valid = 1'b1;
                if ($urandom % 3 != 0) begin
                    cur = tbus_req;
                    tbus_resp.ready = 1'b1;
                end
            end
        end
    end

    initial begin
        wait (table_built);
        repeat (num_rows * 50) @(posedge clock);
        $display("Timeout: the test table did not finish within %0d cycles", num_rows * 50);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n = 1'b0;
        mem_instr_valid = 1'b0;
        mem_issue = '0;
        disp2sq_valid = 1'b0;
        disp2sq_robid = '0;
        commit0 = '0;
        commit1 = '0;
        writes_done = 0;
        writes_expected = 0;
        alloc_count = 0;
        num_rows = 0;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check("tbus_index_valid", 64'(tbus_req.valid), 64'h0);
        check("memwb.valid", 64'(memwb.valid), 64'h0);
        check("mem_instr_ready", 64'(mem_instr_ready), 64'h1);
        check("sq_can_alloc", 64'(sq_can_alloc), 64'h1);
        check("sq2disp_sqid", 64'(sq2disp_sqid), 64'h0);
        for (int i = 0; i < num_rows; i++) begin
            run_step(steps[i]);
        end
        repeat (2) @(negedge clock);
        $display("No errors");
        $finish;
    end

endmodule

//--- filelist.f
verilog/exu_pkg.sv
verilog/dcache_arb.sv
verilog/load_store_unit.sv
verilog/store_queue.sv
verilog/exu_top.sv
bench/exu_tb.sv

//--- verilog/dcache_arb.sv
`timescale 1ns/1ps

module dcache_arb (
    input  logic                clock,
    input  logic                rst_n,
    input  exu_pkg::tbus_req_t  load_req,
    output exu_pkg::tbus_resp_t load_resp,
    input  exu_pkg::tbus_req_t  sq_req,
    output exu_pkg::tbus_resp_t sq_resp,
    output exu_pkg::tbus_req_t  bus_req,
    input  exu_pkg::tbus_resp_t bus_resp
);
    import exu_pkg::*;

    typedef enum logic {
        OWN_LOAD = 1'b0,
        OWN_SQ   = 1'b1
    } owner_t;

    owner_t owner;
    owner_t sel;
    logic   busy;

    // Loads win when the bus is free
    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (load_req.valid) begin
            sel = OWN_LOAD;
        end else begin
            sel = OWN_SQ;
        end
    end

    assign bus_req = (sel == OWN_SQ) ? sq_req : load_req;

    assign load_resp = '{
        ready:          bus_resp.ready && (sel == OWN_LOAD),
        operation_done: bus_resp.operation_done && busy && (owner == OWN_LOAD),
        read_data:      bus_resp.read_data
    };

    assign sq_resp = '{
        ready:          bus_resp.ready && (sel == OWN_SQ),
        operation_done: bus_resp.operation_done && busy && (owner == OWN_SQ),
        read_data:      bus_resp.read_data
    };

    // Lock the owner from its first request until its done pulse
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= OWN_LOAD;
        end else if (busy) begin
            if (bus_resp.operation_done) begin
                busy <= 1'b0;
            end
        end else if (bus_req.valid) begin
            busy  <= 1'b1;
            owner <= sel;
        end
    end

endmodule

//--- verilog/exu_pkg.sv
package exu_pkg;

    localparam int XLEN     = 64;
    localparam int ROB_ID_W = 6;
    localparam int PREG_W   = 6;
    localparam int SQ_DEPTH = 4;

    typedef enum logic [1:0] {
        LS_BYTE   = 2'd0,
        LS_HALF   = 2'd1,
        LS_WORD   = 2'd2,
        LS_DOUBLE = 2'd3
    } ls_size_t;

    typedef enum logic {
        TBUS_READ  = 1'b0,
        TBUS_WRITE = 1'b1
    } tbus_op_t;

    // Memory micro-op as issued
    typedef struct packed {
        logic [ROB_ID_W-1:0] robid;
        logic [ROB_ID_W-1:0] sqid;
        logic [XLEN-1:0]     src1;
        logic [XLEN-1:0]     src2;
        logic [XLEN-1:0]     imm;
        logic [PREG_W-1:0]   prd;
        logic                is_load;
        logic                is_store;
        logic                is_unsigned;
        ls_size_t            ls_size;
    } mem_issue_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] robid;
        logic [PREG_W-1:0]   prd;
        logic                need_to_wb;
        logic [XLEN-1:0]     result;
    } memwb_t;

    // Executed store, lanes already aligned
    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] sqid;
        logic [XLEN-1:0]     addr;
        logic [XLEN-1:0]     data;
        logic [XLEN-1:0]     mask;
    } sq_fill_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] index;
        logic [XLEN-1:0] write_data;
        logic [XLEN-1:0] write_mask;
        tbus_op_t        op_type;
    } tbus_req_t;

    typedef struct packed {
        logic            ready;
        logic            operation_done;
        logic [XLEN-1:0] read_data;
    } tbus_resp_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] robid;
    } commit_t;

endpackage

//--- verilog/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
    parameter int sq_depth = exu_pkg::SQ_DEPTH
) (
    input  logic                            clock,
    input  logic                            rst_n,

    // Issue
    input  logic                            mem_instr_valid,
    output logic                            mem_instr_ready,
    input  exu_pkg::mem_issue_t             mem_issue,

    // Dispatch
    input  logic                            disp2sq_valid,
    input  logic [exu_pkg::ROB_ID_W-1:0]    disp2sq_robid,
    output logic                            sq_can_alloc,
    output logic [exu_pkg::ROB_ID_W-1:0]    sq2disp_sqid,

    // Commit
    input  exu_pkg::commit_t                commit0,
    input  exu_pkg::commit_t                commit1,

    // Writeback
    output exu_pkg::memwb_t                 memwb,

    // Data cache bus
    output exu_pkg::tbus_req_t              tbus_req,
    input  exu_pkg::tbus_resp_t             tbus_resp
);
    import exu_pkg::*;

    tbus_req_t  load_req;
    tbus_resp_t load_resp;
    tbus_req_t  sq_req;
    tbus_resp_t sq_resp;
    sq_fill_t   sq_fill;

    load_store_unit u_load_store_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .instr_valid(mem_instr_valid),
        .instr_ready(mem_instr_ready),
        .issue      (mem_issue),
        .sq_fill    (sq_fill),
        .load_req   (load_req),
        .load_resp  (load_resp),
        .memwb      (memwb)
    );

    store_queue #(
        .depth(sq_depth)
    ) u_store_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .alloc_valid(disp2sq_valid),
        .alloc_robid(disp2sq_robid),
        .can_alloc  (sq_can_alloc),
        .tail_sqid  (sq2disp_sqid),
        .fill       (sq_fill),
        .commit0    (commit0),
        .commit1    (commit1),
        .bus_req    (sq_req),
        .bus_resp   (sq_resp)
    );

    dcache_arb u_dcache_arb (
        .clock    (clock),
        .rst_n    (rst_n),
        .load_req (load_req),
        .load_resp(load_resp),
        .sq_req   (sq_req),
        .sq_resp  (sq_resp),
        .bus_req  (tbus_req),
        .bus_resp (tbus_resp)
    );

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                instr_valid,
    output logic                instr_ready,
    input  exu_pkg::mem_issue_t issue,
    output exu_pkg::sq_fill_t   sq_fill,
    output exu_pkg::tbus_req_t  load_req,
    input  exu_pkg::tbus_resp_t load_resp,
    output exu_pkg::memwb_t     memwb
);
    import exu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_t;

    state_t              state;
    logic                accept;
    logic                load_done;
    logic [XLEN-1:0]     addr;
    logic [2:0]          offset;
    logic [7:0]          byte_mask;
    logic [XLEN-1:0]     bit_mask;
    logic [XLEN-1:0]     lane;

    // Held copy of the accepted op
    logic [ROB_ID_W-1:0] op_robid;
    logic [ROB_ID_W-1:0] op_sqid;
    logic [PREG_W-1:0]   op_prd;
    logic                op_store;
    logic                op_unsigned;
    ls_size_t            op_size;
    logic [XLEN-1:0]     op_addr;
    logic [XLEN-1:0]     op_data;
    logic [XLEN-1:0]     op_mask;

    logic                wb_valid;
    logic                fill_valid;
    logic [XLEN-1:0]     wb_result;

    function automatic logic [7:0] size_bytes(input ls_size_t size);
        case (size)
            LS_BYTE: return 8'h01;
            LS_HALF: return 8'h03;
            LS_WORD: return 8'h0f;
            default: return 8'hff;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] extend(input logic [XLEN-1:0] v,
                                               input ls_size_t size,
                                               input logic uns);
        case (size)
            LS_BYTE: return {{(XLEN-8){~uns & v[7]}}, v[7:0]};
            LS_HALF: return {{(XLEN-16){~uns & v[15]}}, v[15:0]};
            LS_WORD: return {{(XLEN-32){~uns & v[31]}}, v[31:0]};
            default: return v;
        endcase
    endfunction

    assign instr_ready = (state == S_IDLE);
    assign accept      = instr_valid && instr_ready;
    assign load_done   = (state == S_WAIT) && load_resp.operation_done;

    assign addr      = issue.src1 + issue.imm;
    assign offset    = addr[2:0];
    assign byte_mask = size_bytes(issue.ls_size) << offset;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            bit_mask[i*8 +: 8] = {8{byte_mask[i]}};
        end
    end

    // Pick the addressed lane out of the doubleword
    assign lane = load_resp.read_data >> {op_addr[2:0], 3'b000};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (accept && issue.is_load) state <= S_REQ;
                S_REQ: if (load_resp.ready) state <= S_WAIT;
                S_WAIT: if (load_resp.operation_done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            wb_valid   <= (accept && issue.is_store) || load_done;
            fill_valid <= accept && issue.is_store;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            op_robid    <= issue.robid;
            op_sqid     <= issue.sqid;
            op_prd      <= issue.prd;
            op_store    <= issue.is_store;
            op_unsigned <= issue.is_unsigned;
            op_size     <= issue.ls_size;
            op_addr     <= addr;
            op_data     <= issue.src2 << {offset, 3'b000};
            op_mask     <= bit_mask;
        end
        if (load_done) begin
            wb_result <= extend(lane, op_size, op_unsigned);
        end
    end

    assign load_req = '{
        valid:      (state == S_REQ),
        index:      op_addr,
        write_data: '0,
        write_mask: '0,
        op_type:    TBUS_READ
    };

    assign sq_fill = '{
        valid: fill_valid,
        sqid:  op_sqid,
        addr:  op_addr,
        data:  op_data,
        mask:  op_mask
    };

    // Stores retire here without a register write
    assign memwb = '{
        valid:      wb_valid,
        robid:      op_robid,
        prd:        op_prd,
        need_to_wb: ~op_store,
        result:     op_store ? '0 : wb_result
    };

endmodule

//--- verilog/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
    parameter int depth = exu_pkg::SQ_DEPTH
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         alloc_valid,
    input  logic [exu_pkg::ROB_ID_W-1:0] alloc_robid,
    output logic                         can_alloc,
    output logic [exu_pkg::ROB_ID_W-1:0] tail_sqid,
    input  exu_pkg::sq_fill_t            fill,
    input  exu_pkg::commit_t             commit0,
    input  exu_pkg::commit_t             commit1,
    output exu_pkg::tbus_req_t           bus_req,
    input  exu_pkg::tbus_resp_t          bus_resp
);
    import exu_pkg::*;

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    typedef enum logic [1:0] {
        D_IDLE,
        D_REQ,
        D_WAIT
    } drain_t;

    logic [depth-1:0]    ent_valid;
    logic [depth-1:0]    ent_filled;
    logic [depth-1:0]    ent_committed;
    logic [ROB_ID_W-1:0] ent_robid [depth];
    logic [XLEN-1:0]     ent_addr  [depth];
    logic [XLEN-1:0]     ent_data  [depth];
    logic [XLEN-1:0]     ent_mask  [depth];

    // Top bit of each pointer is the wrap flag
    logic [idx_w:0]      head;
    logic [idx_w:0]      tail;
    logic [idx_w-1:0]    head_idx;
    logic [idx_w-1:0]    tail_idx;
    logic [idx_w-1:0]    fill_idx;
    logic                full;
    logic                do_alloc;
    logic                do_free;
    logic                head_ready;
    drain_t              drain;

    function automatic logic [idx_w:0] ptr_inc(input logic [idx_w:0] p);
        if (p[idx_w-1:0] == idx_w'(depth - 1)) begin
            return {~p[idx_w], {idx_w{1'b0}}};
        end
        return p + 1'b1;
    endfunction

    assign head_idx = head[idx_w-1:0];
    assign tail_idx = tail[idx_w-1:0];
    assign fill_idx = fill.sqid[idx_w-1:0];

    assign full      = (head_idx == tail_idx) && (head[idx_w] != tail[idx_w]);
    assign can_alloc = ~full;
    assign tail_sqid = ROB_ID_W'(tail_idx);
    assign do_alloc  = alloc_valid && can_alloc;
    assign do_free   = (drain == D_WAIT) && bus_resp.operation_done;

    assign head_ready = ent_valid[head_idx] && ent_filled[head_idx] && ent_committed[head_idx];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ent_valid     <= '0;
            ent_filled    <= '0;
            ent_committed <= '0;
            head          <= '0;
            tail          <= '0;
            drain         <= D_IDLE;
        end else begin
            for (int i = 0; i < depth; i++) begin
                if (ent_valid[i] &&
                    ((commit0.valid && commit0.robid == ent_robid[i]) ||
                     (commit1.valid && commit1.robid == ent_robid[i]))) begin
                    ent_committed[i] <= 1'b1;
                end
            end

            if (fill.valid) begin
                ent_filled[fill_idx] <= 1'b1;
            end

            if (do_alloc) begin
                ent_valid[tail_idx]     <= 1'b1;
                ent_filled[tail_idx]    <= 1'b0;
                ent_committed[tail_idx] <= 1'b0;
                tail                    <= ptr_inc(tail);
            end

            if (do_free) begin
                ent_valid[head_idx] <= 1'b0;
                head                <= ptr_inc(head);
            end

            case (drain)
                D_IDLE: if (head_ready) drain <= D_REQ;
                D_REQ: if (bus_resp.ready) drain <= D_WAIT;
                D_WAIT: if (bus_resp.operation_done) drain <= D_IDLE;
                default: drain <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_alloc) begin
            ent_robid[tail_idx] <= alloc_robid;
        end
        if (fill.valid) begin
            ent_addr[fill_idx] <= fill.addr;
            ent_data[fill_idx] <= fill.data;
            ent_mask[fill_idx] <= fill.mask;
        end
    end

    // Head entry stays put until its write is done
    assign bus_req = '{
        valid:      (drain == D_REQ),
        index:      ent_addr[head_idx],
        write_data: ent_data[head_idx],
        write_mask: ent_mask[head_idx],
        op_type:    TBUS_WRITE
    };

endmodule
